//--- project.f
hdl/board_cfg_pkg.sv
hdl/board_input_pkg.sv
hdl/board_timer.sv
hdl/board_reset_fsm.sv
hdl/board_inputs.sv
hdl/board_dip.sv
hdl/board_led.sv
hdl/board_top.sv
verif/board_chk.sv
verif/board_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_tb \
    -f project.f \
    -o Vboard_tb

./obj_dir/Vboard_tb | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- verif/board_tb.sv
//////////////////////////////
// Runs with BUTTONS = 3 and ACTIVE_LOW = 1
// Expected table assumes RST_CYCLES = 8, LED_FRAMES = 2
//////////////////////////////
`timescale 1ns/1ps

module board_tb;

    localparam int RST_CYCLES = 8;
    localparam int LED_FRAMES = 2;
    // Tests take about 300 cycles
    localparam int MAX_CYCLES = 2000;
    localparam logic [24:0] CTRL_IDLE = '1;

    typedef struct packed {
        board_input_pkg::board_joy_t        j1;
        board_input_pkg::board_joy_t        j2;
        logic [board_cfg_pkg::STATUS_W-1:0] status;
        logic                               core_mod;
        board_input_pkg::game_ctrl_t        exp_ctrl;
        board_input_pkg::dip_cfg_t          exp_dip;
        logic                               exp_pause;
    } row_t;

    logic clk_sys;
    logic arst_n;
    logic pll_locked;
    logic rst_req;
    logic downloading;
    board_input_pkg::board_joy_t board_joystick1;
    board_input_pkg::board_joy_t board_joystick2;
    logic [board_cfg_pkg::STATUS_W-1:0] status;
    logic core_mod;
    logic osd_shown;
    logic [1:0] game_led;
    logic LVBL;
    logic rst;
    logic game_rst;
    board_input_pkg::game_ctrl_t game_ctrl;
    board_input_pkg::dip_cfg_t dip_cfg;
    logic dip_pause;
    logic led;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    row_t rows[$];

    board_top #(
        .BUTTONS    ( 3          ),
        .ACTIVE_LOW ( 1          ),
        .RST_CYCLES ( RST_CYCLES ),
        .LED_FRAMES ( LED_FRAMES )
    ) i_board_top (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .pll_locked      ( pll_locked      ),
        .rst_req         ( rst_req         ),
        .downloading     ( downloading     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .status          ( status          ),
        .core_mod        ( core_mod        ),
        .osd_shown       ( osd_shown       ),
        .game_led        ( game_led        ),
        .LVBL            ( LVBL            ),
        .rst             ( rst             ),
        .game_rst        ( game_rst        ),
        .game_ctrl       ( game_ctrl       ),
        .dip_cfg         ( dip_cfg         ),
        .dip_pause       ( dip_pause       ),
        .led             ( led             )
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0d ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_range(input string what, input int n, input int lo, input int hi);
        assert (n >= lo && n <= hi) else begin
            $display("%0d ns: %s took %0d cycles, expected %0d to %0d", $time, what, n, lo, hi);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // Counts edges until the chosen reset reaches level
    // rst_seen records any rst high on the way
    task automatic wait_level(input bit game, input logic level, input int limit,
                              output int n, output logic rst_seen);
        n = 0;
        rst_seen = 1'b0;
        do begin
            @(posedge clk_sys);
            #1;
            n++;
            if (rst) rst_seen = 1'b1;
        end while ((game ? game_rst : rst) !== level && n < limit);
    endtask

    // m is {service, coin, start}
    task automatic add_row(input logic [9:0] c1, input logic [2:0] m1,
                           input logic [9:0] c2, input logic [2:0] m2,
                           input logic [31:0] st, input logic cm,
                           input logic [24:0] ctrl, input logic [7:0] dip, input logic pause);
        row_t r;
        r.j1 = {2'b00, 1'b0, m1, c1};
        r.j2 = {2'b00, 1'b0, m2, c2};
        r.status = st;
        r.core_mod = cm;
        r.exp_ctrl = ctrl;
        r.exp_dip = dip;
        r.exp_pause = pause;
        rows.push_back(r);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int err0;
        r = rows[idx];
        err0 = errors;
        r.j1.spare = 2'($urandom);
        r.j2.spare = 2'($urandom);
        @(posedge clk_sys);
        board_joystick1 <= r.j1;
        board_joystick2 <= r.j2;
        status          <= r.status;
        core_mod        <= r.core_mod;
        // Rotation passes through dip_cfg first
        repeat (2) @(posedge clk_sys);
        #1;
        check_val("game_ctrl", 32'(game_ctrl), 32'(r.exp_ctrl));
        check_val("dip_cfg", 32'(dip_cfg), 32'(r.exp_dip));
        check_val("dip_pause", 32'(dip_pause), 32'(r.exp_pause));
        finish_test($sformatf("table row %0d", idx), err0);
    endtask

    task automatic pulse_pause(input bit second, input logic exp);
        @(posedge clk_sys);
        if (second) board_joystick2.pause <= 1'b1;
        else board_joystick1.pause <= 1'b1;
        repeat (2) @(posedge clk_sys);
        board_joystick1.pause <= 1'b0;
        board_joystick2.pause <= 1'b0;
        #1;
        check_val("dip_pause", 32'(dip_pause), 32'(exp));
    endtask

    // One frame of 20 cycles with LVBL low for two
    task automatic run_frame;
        @(posedge clk_sys);
        LVBL <= 1'b0;
        repeat (2) @(posedge clk_sys);
        LVBL <= 1'b1;
        repeat (17) @(posedge clk_sys);
        #1;
    endtask

    task automatic led_step(input logic osd, input logic [1:0] gled, input logic exp);
        @(posedge clk_sys);
        osd_shown <= osd;
        game_led  <= gled;
        @(posedge clk_sys);
        #1;
        check_val("led", 32'(led), 32'(exp));
    endtask

    initial begin
        int err0;
        int n;
        logic seen;
        logic led_exp;
        void'($urandom(87));
        arst_n = 1'b0;
        pll_locked = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        status = '0;
        core_mod = 1'b0;
        osd_shown = 1'b0;
        game_led = 2'b00;
        LVBL = 1'b1;

        // Inputs idle, outputs inactive
        add_row(10'h000, 3'b000, 10'h000, 3'b000, 32'h000, 1'b0,
                {10'h3FF, 10'h3FF, 2'b11, 2'b11, 1'b1}, 8'h18, 1'b1);
        // Buttons 4 to 6 masked
        add_row(10'h3FF, 3'b000, 10'h000, 3'b000, 32'h000, 1'b0,
                {10'h380, 10'h3FF, 2'b11, 2'b11, 1'b1}, 8'h18, 1'b1);
        add_row(10'h000, 3'b000, 10'h0A5, 3'b000, 32'h000, 1'b0,
                {10'h3FF, 10'h3DA, 2'b11, 2'b11, 1'b1}, 8'h18, 1'b1);
        add_row(10'h000, 3'b010, 10'h000, 3'b101, 32'h000, 1'b0,
                {10'h3FF, 10'h3FF, 2'b10, 2'b01, 1'b0}, 8'h18, 1'b1);
        add_row(10'h000, 3'b001, 10'h000, 3'b010, 32'h000, 1'b0,
                {10'h3FF, 10'h3FF, 2'b01, 2'b10, 1'b1}, 8'h18, 1'b1);
        // Rotation on vertical game
        add_row(10'h008, 3'b000, 10'h001, 3'b000, 32'h002, 1'b1,
                {10'h3FE, 10'h3FB, 2'b11, 2'b11, 1'b1}, 8'h98, 1'b1);
        add_row(10'h012, 3'b000, 10'h004, 3'b000, 32'h002, 1'b1,
                {10'h3E7, 10'h3FD, 2'b11, 2'b11, 1'b1}, 8'h98, 1'b1);
        add_row(10'h008, 3'b000, 10'h001, 3'b000, 32'h002, 1'b0,
                {10'h3F7, 10'h3FE, 2'b11, 2'b11, 1'b1}, 8'h18, 1'b1);
        add_row(10'h008, 3'b000, 10'h004, 3'b000, 32'h000, 1'b1,
                {10'h3F7, 10'h3FB, 2'b11, 2'b11, 1'b1}, 8'h18, 1'b1);
        // DIP decoding
        add_row(10'h000, 3'b000, 10'h000, 3'b000, 32'h00C, 1'b0, CTRL_IDLE, 8'h78, 1'b1);
        add_row(10'h000, 3'b000, 10'h000, 3'b000, 32'h070, 1'b0, CTRL_IDLE, 8'h02, 1'b1);
        add_row(10'h000, 3'b000, 10'h000, 3'b000, 32'h0A0, 1'b0, CTRL_IDLE, 8'h14, 1'b1);
        add_row(10'h000, 3'b000, 10'h000, 3'b000, 32'h100, 1'b0, CTRL_IDLE, 8'h19, 1'b0);

        err0 = errors;
        repeat (15) @(posedge clk_sys);
        #1;
        check_val("rst", 32'(rst), 32'd1);
        check_val("game_rst", 32'(game_rst), 32'd1);
        check_val("led", 32'(led), 32'd0);
        check_val("game_ctrl", 32'(game_ctrl), 32'(CTRL_IDLE));
        check_val("dip_pause", 32'(dip_pause), 32'd1);
        @(posedge clk_sys);
        arst_n <= 1'b1;
        wait_level(1'b0, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("rst release", n, RST_CYCLES, RST_CYCLES + 4);
        check_val("game_rst", 32'(game_rst), 32'd1);
        check_val("game_ctrl", 32'(game_ctrl), 32'(CTRL_IDLE));
        check_val("dip_pause", 32'(dip_pause), 32'd1);
        check_val("led", 32'(led), 32'd0);
        wait_level(1'b1, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("game_rst release", n, RST_CYCLES, RST_CYCLES + 4);
        finish_test("reset release", err0);

        err0 = errors;
        @(posedge clk_sys);
        rst_req <= 1'b1;
        @(posedge clk_sys);
        rst_req <= 1'b0;
        #1;
        check_val("game_rst", 32'(game_rst), 32'd1);
        wait_level(1'b1, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("game-only reset", n, RST_CYCLES, RST_CYCLES + 4);
        assert (!seen) else begin
            $display("%0d ns: rst rose during a game-only reset", $time);
            errors++;
        end
        @(posedge clk_sys);
        pll_locked <= 1'b0;
        wait_level(1'b0, 1'b1, 4, n, seen);
        check_range("rst rise on lock loss", n, 1, 2);
        check_val("game_rst", 32'(game_rst), 32'd1);
        @(posedge clk_sys);
        pll_locked <= 1'b1;
        wait_level(1'b0, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("rst release after relock", n, RST_CYCLES, RST_CYCLES + 4);
        wait_level(1'b1, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("game_rst release after relock", n, RST_CYCLES, RST_CYCLES + 4);
        finish_test("game reset and lock loss", err0);

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end

        err0 = errors;
        apply_row(0);
        pulse_pause(1'b0, 1'b0);
        pulse_pause(1'b1, 1'b1);
        finish_test("pause toggle", err0);

        err0 = errors;
        @(posedge clk_sys);
        downloading <= 1'b1;
        led_exp = 1'b0;
        for (int f = 1; f <= 3 * LED_FRAMES; f++) begin
            run_frame();
            if (f % LED_FRAMES == 0) led_exp = ~led_exp;
            check_val("led", 32'(led), 32'(led_exp));
            check_val("game_rst", 32'(game_rst), 32'd1);
            check_val("rst", 32'(rst), 32'd0);
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        wait_level(1'b1, 1'b0, RST_CYCLES + 6, n, seen);
        check_range("game_rst after download", n, RST_CYCLES, RST_CYCLES + 4);
        led_step(1'b1, 2'b00, 1'b1);
        led_step(1'b0, 2'b00, 1'b0);
        led_step(1'b0, 2'b01, 1'b1);
        led_step(1'b0, 2'b10, 1'b0);
        finish_test("led", err0);

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/board_chk.sv
//////////////////////////////
// Bound into board_top
// Sampled on clk_sys, off in arst_n
//////////////////////////////
`timescale 1ns/1ps

module board_chk (
    input logic clk_sys,
    input logic arst_n,
    input logic rst,
    input logic game_rst,
    input logic rst_req,
    input logic led
);

    // System reset always carries the game reset
    a_rst_game: assert property (
        @(posedge clk_sys) disable iff (!arst_n) rst |-> game_rst
    ) else $error("game_rst low while rst is high");

    a_led_off: assert property (
        @(posedge clk_sys) disable iff (!arst_n) rst |-> !led
    ) else $error("led lit while rst is high");

    // Request while running re-arms the game reset
    a_req_game: assert property (
        @(posedge clk_sys) disable iff (!arst_n) (!game_rst && rst_req) |=> game_rst
    ) else $error("rst_req while running gave no game_rst");

endmodule

bind board_top board_chk u_chk (
    .clk_sys  ( clk_sys  ),
    .arst_n   ( arst_n   ),
    .rst      ( rst      ),
    .game_rst ( game_rst ),
    .rst_req  ( rst_req  ),
    .led      ( led      )
);

//--- hdl/board_top.sv
//////////////////////////////
// Single clock domain, clk_sys only
// Two players, no keyboard merging
//////////////////////////////
`timescale 1ns/1ps

module board_top #(
    parameter int BUTTONS    = 3,
    parameter int ACTIVE_LOW = 1,
    parameter int RST_CYCLES = 64,
    parameter int LED_FRAMES = 8,
    parameter int TIMER_W    = 8
) (
    input  logic                               clk_sys,
    input  logic                               arst_n,
    input  logic                               pll_locked,
    input  logic                               rst_req,
    input  logic                               downloading,
    input  board_input_pkg::board_joy_t        board_joystick1,
    input  board_input_pkg::board_joy_t        board_joystick2,
    input  logic [board_cfg_pkg::STATUS_W-1:0] status,
    input  logic                               core_mod,
    input  logic                               osd_shown,
    input  logic [1:0]                         game_led,
    input  logic                               LVBL,
    output logic                               rst,
    output logic                               game_rst,
    output board_input_pkg::game_ctrl_t        game_ctrl,
    output board_input_pkg::dip_cfg_t          dip_cfg,
    output logic                               dip_pause,
    output logic                               led
);

    logic game_pause;

    board_reset_fsm #(
        .RST_CYCLES ( RST_CYCLES ),
        .TIMER_W    ( TIMER_W    )
    ) u_reset (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    board_inputs #(
        .BUTTONS    ( BUTTONS    ),
        .ACTIVE_LOW ( ACTIVE_LOW )
    ) u_inputs (
        .clk_sys         ( clk_sys             ),
        .rst             ( rst                 ),
        .board_joystick1 ( board_joystick1     ),
        .board_joystick2 ( board_joystick2     ),
        .rot_control     ( dip_cfg.rot_control ),
        .game_ctrl       ( game_ctrl           ),
        .game_pause      ( game_pause          )
    );

    board_dip u_dip (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .status     ( status     ),
        .core_mod   ( core_mod   ),
        .game_pause ( game_pause ),
        .dip_cfg    ( dip_cfg    ),
        .dip_pause  ( dip_pause  )
    );

    board_led #(
        .LED_FRAMES ( LED_FRAMES ),
        .TIMER_W    ( TIMER_W    )
    ) u_led (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .LVBL        ( LVBL        ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

//--- hdl/board_led.sv
//////////////////////////////
// LVBL active low, one frame per fall
// LED_FRAMES must fit in TIMER_W bits
//////////////////////////////
`timescale 1ns/1ps

module board_led #(
    parameter int LED_FRAMES = 8,
    parameter int TIMER_W    = 8
) (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       LVBL,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    board_cfg_pkg::led_src_e led_src;
    logic lvbl_q;
    logic frame_tick;
    logic tmr_done;
    logic tmr_arst_n;

    assign frame_tick = lvbl_q & ~LVBL;
    assign tmr_arst_n = ~rst;

    always_comb begin
        if (downloading) led_src = board_cfg_pkg::LED_BLINK;
        else if (osd_shown) led_src = board_cfg_pkg::LED_OSD;
        else led_src = board_cfg_pkg::LED_GAME;
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            lvbl_q <= 1'b1;
            led    <= 1'b0;
        end else begin
            lvbl_q <= LVBL;
            case (led_src)
                board_cfg_pkg::LED_BLINK: if (tmr_done) led <= ~led;
                board_cfg_pkg::LED_OSD:   led <= 1'b1;
                default:                  led <= game_led[0];
            endcase
        end
    end

    // Frame counter, reloaded whenever no download runs
    board_timer #(
        .TIMER_W ( TIMER_W )
    ) u_timer (
        .clk_sys ( clk_sys                   ),
        .arst_n  ( tmr_arst_n                ),
        .load    ( ~downloading | tmr_done   ),
        .value   ( TIMER_W'(LED_FRAMES)      ),
        .tick    ( frame_tick                ),
        .done    ( tmr_done                  )
    );

endmodule

//--- hdl/board_dip.sv
//////////////////////////////
// core_mod is bit 0, vertical game
// dip_pause active low
//////////////////////////////
`timescale 1ns/1ps

module board_dip (
    input  logic                               clk_sys,
    input  logic                               rst,
    input  logic [board_cfg_pkg::STATUS_W-1:0] status,
    input  logic                               core_mod,
    input  logic                               game_pause,
    output board_input_pkg::dip_cfg_t          dip_cfg,
    output logic                               dip_pause
);

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            dip_cfg   <= '0;
            dip_pause <= 1'b1;
        end else begin
            // Rotation only matters for vertical games
            dip_cfg.rot_control <= status[board_cfg_pkg::ST_ROTATE] & core_mod;
            dip_cfg.flip        <= status[board_cfg_pkg::ST_FLIP];
            dip_cfg.test        <= status[board_cfg_pkg::ST_TEST];
            dip_cfg.enable_fm   <= ~status[board_cfg_pkg::ST_NOFM];
            dip_cfg.enable_psg  <= ~status[board_cfg_pkg::ST_NOPSG];
            dip_cfg.fxlevel     <= {status[board_cfg_pkg::ST_FXHI],
                                    status[board_cfg_pkg::ST_FXLO]};
            dip_cfg.osd_pause   <= status[board_cfg_pkg::ST_OSDPAUSE];
            dip_pause           <= ~(game_pause | status[board_cfg_pkg::ST_OSDPAUSE]);
        end
    end

endmodule

//--- hdl/board_inputs.sv
//////////////////////////////
// BUTTONS from 1 to 6
// game_pause stays active high
//////////////////////////////
`timescale 1ns/1ps

module board_inputs #(
    parameter int BUTTONS    = 3,
    parameter int ACTIVE_LOW = 1
) (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  board_input_pkg::board_joy_t board_joystick1,
    input  board_input_pkg::board_joy_t board_joystick2,
    input  logic                        rot_control,
    output board_input_pkg::game_ctrl_t game_ctrl,
    output logic                        game_pause
);

    localparam int JW = board_cfg_pkg::GAME_JOY_W;
    // Directions plus the buttons in use
    localparam logic [JW-1:0] CTRL_MASK = {JW{1'b1}} >> (JW - 4 - BUTTONS);

    board_input_pkg::game_ctrl_t ctrl_nxt;
    logic [1:0] pause_q;
    logic [1:0] pause_rise;

    function automatic logic [JW-1:0] map_ctrl(input logic [JW-1:0] ctrl, input logic rot);
        logic [JW-1:0] m;
        m = ctrl & CTRL_MASK;
        if (rot) begin
            m[0] = ctrl[3];
            m[1] = ctrl[2];
            m[2] = ctrl[0];
            m[3] = ctrl[1];
        end
        return m;
    endfunction

    always_comb begin
        ctrl_nxt.joy1    = map_ctrl(board_joystick1.ctrl, rot_control);
        ctrl_nxt.joy2    = map_ctrl(board_joystick2.ctrl, rot_control);
        ctrl_nxt.coin    = {board_joystick2.coin, board_joystick1.coin};
        ctrl_nxt.start   = {board_joystick2.start, board_joystick1.start};
        ctrl_nxt.service = board_joystick1.service | board_joystick2.service;
    end

    assign pause_rise = {board_joystick2.pause, board_joystick1.pause} & ~pause_q;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            game_ctrl  <= {$bits(game_ctrl){ACTIVE_LOW != 0}};
            pause_q    <= 2'b00;
            game_pause <= 1'b0;
        end else begin
            game_ctrl  <= ACTIVE_LOW != 0 ? ~ctrl_nxt : ctrl_nxt;
            pause_q    <= {board_joystick2.pause, board_joystick1.pause};
            if (|pause_rise) game_pause <= ~game_pause;
        end
    end

endmodule

//--- hdl/board_reset_fsm.sv
//////////////////////////////
// RST_CYCLES must fit in TIMER_W bits
// Lock loss resets from any state
//////////////////////////////
`timescale 1ns/1ps

module board_reset_fsm #(
    parameter int RST_CYCLES = 64,
    parameter int TIMER_W    = 8
) (
    input  logic clk_sys,
    input  logic arst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    output logic rst,
    output logic game_rst
);

    board_cfg_pkg::rst_state_e state, state_nxt;
    logic tmr_load;
    logic tmr_done;

    always_comb begin
        state_nxt = state;
        tmr_load  = 1'b0;
        case (state)
            board_cfg_pkg::RST_LOCK: begin
                if (pll_locked) begin
                    state_nxt = board_cfg_pkg::RST_SYS;
                    tmr_load  = 1'b1;
                end
            end
            board_cfg_pkg::RST_SYS: begin
                if (tmr_done) begin
                    state_nxt = board_cfg_pkg::RST_GAME;
                    tmr_load  = 1'b1;
                end
            end
            board_cfg_pkg::RST_GAME: begin
                // Hold the count while a download is running
                if (downloading) tmr_load = 1'b1;
                else if (tmr_done) state_nxt = board_cfg_pkg::RST_RUN;
            end
            default: begin
                if (rst_req || downloading) begin
                    state_nxt = board_cfg_pkg::RST_GAME;
                    tmr_load  = 1'b1;
                end
            end
        endcase
        if (!pll_locked) state_nxt = board_cfg_pkg::RST_LOCK;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= board_cfg_pkg::RST_LOCK;
            rst      <= 1'b1;
            game_rst <= 1'b1;
        end else begin
            state    <= state_nxt;
            rst      <= state_nxt == board_cfg_pkg::RST_LOCK ||
                        state_nxt == board_cfg_pkg::RST_SYS;
            game_rst <= state_nxt != board_cfg_pkg::RST_RUN;
        end
    end

    // Counts clock cycles
    board_timer #(
        .TIMER_W ( TIMER_W )
    ) u_timer (
        .clk_sys ( clk_sys                 ),
        .arst_n  ( arst_n                  ),
        .load    ( tmr_load                ),
        .value   ( TIMER_W'(RST_CYCLES)    ),
        .tick    ( 1'b1                    ),
        .done    ( tmr_done                )
    );

endmodule

//--- hdl/board_timer.sv
//////////////////////////////
// Load wins over tick
// A zero load never gives done
//////////////////////////////
`timescale 1ns/1ps

module board_timer #(
    parameter int TIMER_W = 8
) (
    input  logic               clk_sys,
    input  logic               arst_n,
    input  logic               load,
    input  logic [TIMER_W-1:0] value,
    input  logic               tick,
    output logic               done
);

    logic [TIMER_W-1:0] cnt;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                cnt <= value;
            end else if (tick && cnt != '0) begin
                cnt  <= cnt - 1'b1;
                // Last step down to zero
                done <= cnt == TIMER_W'(1);
            end
        end
    end

endmodule

//--- hdl/board_input_pkg.sv
//////////////////////////////
// Board joysticks are active high
// Game side polarity set by ACTIVE_LOW
//////////////////////////////
package board_input_pkg;

    // Bit 0 right, 1 left, 2 down, 3 up, 4..9 buttons 1..6
    typedef struct packed {
        logic [board_cfg_pkg::BOARD_JOY_W-board_cfg_pkg::GAME_JOY_W-5:0] spare;
        logic                                  pause;
        logic                                  service;
        logic                                  coin;
        logic                                  start;
        logic [board_cfg_pkg::GAME_JOY_W-1:0]  ctrl;
    } board_joy_t;

    typedef struct packed {
        logic [board_cfg_pkg::GAME_JOY_W-1:0] joy1;
        logic [board_cfg_pkg::GAME_JOY_W-1:0] joy2;
        logic [1:0]                           coin;
        logic [1:0]                           start;
        logic                                 service;
    } game_ctrl_t;

    typedef struct packed {
        logic       rot_control;
        logic       flip;
        logic       test;
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;
        logic       osd_pause;
    } dip_cfg_t;

endpackage

//--- hdl/board_cfg_pkg.sv
//////////////////////////////
// Status bit positions follow the OSD menu layout
// Widths assume one 32-bit status word
//////////////////////////////
package board_cfg_pkg;

    localparam int STATUS_W    = 32;
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;

    // OSD status word bit positions
    localparam int ST_ROTATE   = 1;
    localparam int ST_FLIP     = 2;
    localparam int ST_TEST     = 3;
    localparam int ST_NOFM     = 4;
    localparam int ST_NOPSG    = 5;
    localparam int ST_FXLO     = 6;
    localparam int ST_FXHI     = 7;
    localparam int ST_OSDPAUSE = 8;

    typedef enum logic [1:0] {
        RST_LOCK,
        RST_SYS,
        RST_GAME,
        RST_RUN
    } rst_state_e;

    // LED source select
    typedef enum logic [1:0] {
        LED_BLINK,
        LED_OSD,
        LED_GAME
    } led_src_e;

endpackage
